//--- add_bus_if.sv
`timescale 1ns/10ps

interface add_bus_if;

  import ngemm_cfg_pkg::*;
  import ngemm_inst_pkg::*;

  // One operation per valid cycle
  logic      valid;
  add_mode_e mode;

  // Operands for add and subtract, ignored while accumulating
  matrix_t   a;
  matrix_t   b;

  modport seq
  (
    output valid,
    output mode,
    output a,
    output b
  );

  modport lane
  (
    input  valid,
    input  mode,
    input  a,
    input  b
  );

endinterface

//--- add_sub_array.sv
`timescale 1ns/10ps

module add_sub_array
(
  input  logic                   dca_port_15,
  input  logic                   dca_port_13,
  add_bus_if.lane                add_bus,
  input  ngemm_cfg_pkg::matrix_t i_prod,
  output ngemm_cfg_pkg::matrix_t o_sum
);

  import ngemm_cfg_pkg::*;
  import ngemm_inst_pkg::*;

  // ******************************
  // Sixteen add/sub/acc lanes
  // ******************************

  always_ff @(posedge dca_port_15, negedge dca_port_13)
  begin
    if (!dca_port_13)
      o_sum <= '0;
    else if (add_bus.valid)
    begin
      for (int r = 0; r < MAT_DIM; r++)
      begin
        for (int c = 0; c < MAT_DIM; c++)
        begin
          case (add_bus.mode)
            AM_ADD:
              o_sum[r][c] <= add_bus.a[r][c] + add_bus.b[r][c];
            AM_SUB:
              o_sum[r][c] <= add_bus.a[r][c] - add_bus.b[r][c];
            // First partial product starts a fresh sum
            AM_ACC_FIRST:
              o_sum[r][c] <= i_prod[r][c];
            AM_ACC:
              o_sum[r][c] <= o_sum[r][c] + i_prod[r][c];
            default:
              o_sum[r][c] <= o_sum[r][c];
          endcase
        end
      end
    end
  end

endmodule

//--- mult_array.sv
`timescale 1ns/10ps

module mult_array
(
  input  logic                   dca_port_15,
  input  logic                   dca_port_13,
  input  logic                   i_mul_valid,
  input  ngemm_cfg_pkg::matrix_t i_mul_a,
  input  ngemm_cfg_pkg::matrix_t i_mul_b,
  output ngemm_cfg_pkg::matrix_t o_prod
);

  import ngemm_cfg_pkg::*;

  // ******************************
  // Sixteen multiply lanes
  // ******************************

  // Keeps the low half of each product, wraps like the adder
  always_ff @(posedge dca_port_15, negedge dca_port_13)
  begin
    if (!dca_port_13)
      o_prod <= '0;
    else if (i_mul_valid)
    begin
      for (int r = 0; r < MAT_DIM; r++)
      begin
        for (int c = 0; c < MAT_DIM; c++)
        begin
          o_prod[r][c] <= i_mul_a[r][c] * i_mul_b[r][c];
        end
      end
    end
  end

endmodule

//--- ngemm_cfg_pkg.sv
package ngemm_cfg_pkg;

  // ******************************
  // Tile geometry
  // ******************************

  localparam int MAT_DIM  = 4;
  localparam int ELEM_W   = 16;
  localparam int NUM_ELEM = MAT_DIM * MAT_DIM;

  // Inner dimension count, 1 to MAT_DIM plus the write-back step
  localparam int DIM_W    = 3;
  localparam int IDX_W    = $clog2(MAT_DIM);

  // ******************************
  // Element and tile types
  // ******************************

  typedef logic [ELEM_W-1:0] elem_t;

  // Row-major, element (r,c) is m[r][c]
  typedef elem_t [MAT_DIM-1:0][MAT_DIM-1:0] matrix_t;

  typedef logic [MAT_DIM-1:0] dim_mask_t;

  // Bit index is row*MAT_DIM+col
  typedef logic [NUM_ELEM-1:0] elem_mask_t;

endpackage

//--- ngemm_inst_pkg.sv
package ngemm_inst_pkg;

  import ngemm_cfg_pkg::*;

  // ******************************
  // Operation codes
  // ******************************

  typedef enum logic [1:0]
  {
    OP_ADD    = 2'd0,
    OP_SUB    = 2'd1,
    OP_EWMULT = 2'd2,
    OP_MATMUL = 2'd3
  } op_e;

  // Adder lane modes
  typedef enum logic [1:0]
  {
    AM_ADD       = 2'd0,
    AM_SUB       = 2'd1,
    AM_ACC_FIRST = 2'd2,
    AM_ACC       = 2'd3
  } add_mode_e;

  // Which lane array holds the finished result
  typedef enum logic
  {
    SRC_ADD = 1'b0,
    SRC_MUL = 1'b1
  } src_e;

  // ******************************
  // Instruction word
  // ******************************

  typedef struct packed
  {
    op_e              op;
    dim_mask_t        row_mask;
    dim_mask_t        col_mask;
    logic [DIM_W-1:0] k_dim;
  } inst_t;

endpackage

//--- ngemm_sequencer.sv
`timescale 1ns/10ps

module ngemm_sequencer
(
  input  logic                   dca_port_15,
  input  logic                   dca_port_13,
  input  logic                   i_clear,
  input  logic                   i_start,
  input  ngemm_inst_pkg::inst_t  i_inst,
  input  ngemm_cfg_pkg::matrix_t i_lhs,
  input  ngemm_cfg_pkg::matrix_t i_rhs,
  output logic                   o_busy,
  output logic                   o_mul_valid,
  output ngemm_cfg_pkg::matrix_t o_mul_a,
  output ngemm_cfg_pkg::matrix_t o_mul_b,
  add_bus_if.seq                 add_bus,
  wb_bus_if.seq                  wb_bus
);

  import ngemm_cfg_pkg::*;
  import ngemm_inst_pkg::*;

  logic             run_q;
  logic [DIM_W-1:0] step_q;
  logic             acc_vld_q;

  inst_t            inst_q;
  logic [DIM_W-1:0] k_q;
  matrix_t          lhs_q;
  matrix_t          rhs_q;

  logic             accept;
  logic             is_mm;
  logic [DIM_W-1:0] k_eff;
  logic [DIM_W-1:0] last_step;
  logic [IDX_W-1:0] k_idx;
  logic             wb_fire;

  assign accept = ~run_q & i_start;

  // Zero behaves as one, oversize is held to the tile width
  always_comb
  begin
    k_eff = i_inst.k_dim;
    if (i_inst.k_dim == '0)
      k_eff = DIM_W'(1);
    else if (i_inst.k_dim > DIM_W'(MAT_DIM))
      k_eff = DIM_W'(MAT_DIM);
  end

  // ******************************
  // Control state
  // ******************************

  always_ff @(posedge dca_port_15, negedge dca_port_13)
  begin
    if (!dca_port_13)
    begin
      run_q     <= 1'b0;
      step_q    <= '0;
      acc_vld_q <= 1'b0;
    end
    else if (i_clear)
    begin
      run_q     <= 1'b0;
      step_q    <= '0;
      acc_vld_q <= 1'b0;
    end
    else if (accept)
    begin
      run_q     <= 1'b1;
      step_q    <= '0;
      acc_vld_q <= 1'b0;
    end
    else if (run_q)
    begin
      // Accumulate trails its multiply by one cycle
      acc_vld_q <= o_mul_valid & is_mm;
      if (wb_fire)
      begin
        run_q  <= 1'b0;
        step_q <= '0;
      end
      else
        step_q <= step_q + 1'b1;
    end
  end

  always_ff @(posedge dca_port_15)
  begin
    if (accept)
    begin
      inst_q <= i_inst;
      k_q    <= k_eff;
      lhs_q  <= i_lhs;
      rhs_q  <= i_rhs;
    end
  end

  assign is_mm     = (inst_q.op == OP_MATMUL);
  assign last_step = is_mm ? k_q + 1'b1 : DIM_W'(1);
  assign k_idx     = step_q[IDX_W-1:0];
  assign wb_fire   = run_q & ~i_clear & (step_q == last_step);
  assign o_busy    = run_q;

  // ******************************
  // Multiplier issue
  // ******************************

  always_comb
  begin
    o_mul_valid = 1'b0;
    if (run_q)
    begin
      if (inst_q.op == OP_EWMULT)
        o_mul_valid = (step_q == '0);
      else if (is_mm)
        o_mul_valid = (step_q < k_q);
    end
  end

  // Step k spreads lhs column k along rows and rhs row k along columns
  always_comb
  begin
    for (int r = 0; r < MAT_DIM; r++)
    begin
      for (int c = 0; c < MAT_DIM; c++)
      begin
        if (is_mm)
        begin
          o_mul_a[r][c] = lhs_q[r][k_idx];
          o_mul_b[r][c] = rhs_q[k_idx][c];
        end
        else
        begin
          o_mul_a[r][c] = lhs_q[r][c];
          o_mul_b[r][c] = rhs_q[r][c];
        end
      end
    end
  end

  // ******************************
  // Adder issue and write-back
  // ******************************

  always_comb
  begin
    add_bus.valid = 1'b0;
    add_bus.mode  = AM_ADD;
    add_bus.a     = lhs_q;
    add_bus.b     = rhs_q;
    if (run_q)
    begin
      case (inst_q.op)
        OP_ADD:
          add_bus.valid = (step_q == '0);
        OP_SUB:
        begin
          add_bus.valid = (step_q == '0);
          add_bus.mode  = AM_SUB;
        end
        OP_MATMUL:
        begin
          add_bus.valid = acc_vld_q;
          add_bus.mode  = (step_q == DIM_W'(1)) ? AM_ACC_FIRST : AM_ACC;
        end
        default:
          add_bus.valid = 1'b0;
      endcase
    end
  end

  assign wb_bus.valid    = wb_fire;
  assign wb_bus.src      = (inst_q.op == OP_EWMULT) ? SRC_MUL : SRC_ADD;
  assign wb_bus.row_mask = inst_q.row_mask;
  assign wb_bus.col_mask = inst_q.col_mask;

endmodule

//--- ngemm_tb_clock.sv
`timescale 1ns/10ps

module ngemm_tb_clock
(
  output logic o_clk,
  output logic o_rst_n
);

  localparam int HALF_PERIOD  = 5;
  localparam int RESET_CYCLES = 2;

  initial
  begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  // Reset leaves on a falling edge, clear of the sampling edge
  initial
  begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

//--- ngemm_unit.f
ngemm_cfg_pkg.sv
ngemm_inst_pkg.sv
add_bus_if.sv
wb_bus_if.sv
ngemm_sequencer.sv
add_sub_array.sv
mult_array.sv
result_writer.sv
ngemm_unit.sv
ngemm_tb_clock.sv
ngemm_unit_tb.sv

//--- ngemm_unit.sv
`timescale 1ns/10ps

module ngemm_unit
(
  input  logic                              dca_port_15,
  input  logic                              dca_port_13,
  input  logic                              i_clear,
  input  logic                              i_start,
  input  ngemm_inst_pkg::op_e               i_op,
  input  ngemm_cfg_pkg::dim_mask_t          i_row_mask,
  input  ngemm_cfg_pkg::dim_mask_t          i_col_mask,
  input  logic [ngemm_cfg_pkg::DIM_W-1:0]   i_k_dim,
  input  ngemm_cfg_pkg::matrix_t            i_lhs,
  input  ngemm_cfg_pkg::matrix_t            i_rhs,
  output logic                              o_busy,
  output logic                              o_done,
  output ngemm_cfg_pkg::matrix_t            o_result,
  output ngemm_cfg_pkg::elem_mask_t         o_wmask
);

  import ngemm_cfg_pkg::*;
  import ngemm_inst_pkg::*;

  inst_t   inst;
  logic    mul_valid;
  matrix_t mul_a;
  matrix_t mul_b;
  matrix_t prod;
  matrix_t sum;

  add_bus_if u_add_bus ();
  wb_bus_if  u_wb_bus ();

  assign inst = '{op: i_op, row_mask: i_row_mask, col_mask: i_col_mask, k_dim: i_k_dim};

  // ******************************
  // Control and datapath blocks
  // ******************************

  ngemm_sequencer u_sequencer
  (
    .dca_port_15 (dca_port_15),
    .dca_port_13 (dca_port_13),
    .i_clear     (i_clear),
    .i_start     (i_start),
    .i_inst      (inst),
    .i_lhs       (i_lhs),
    .i_rhs       (i_rhs),
    .o_busy      (o_busy),
    .o_mul_valid (mul_valid),
    .o_mul_a     (mul_a),
    .o_mul_b     (mul_b),
    .add_bus     (u_add_bus),
    .wb_bus      (u_wb_bus)
  );

  add_sub_array u_add_sub_array
  (
    .dca_port_15 (dca_port_15),
    .dca_port_13 (dca_port_13),
    .add_bus     (u_add_bus),
    .i_prod      (prod),
    .o_sum       (sum)
  );

  mult_array u_mult_array
  (
    .dca_port_15 (dca_port_15),
    .dca_port_13 (dca_port_13),
    .i_mul_valid (mul_valid),
    .i_mul_a     (mul_a),
    .i_mul_b     (mul_b),
    .o_prod      (prod)
  );

  result_writer u_result_writer
  (
    .dca_port_15 (dca_port_15),
    .dca_port_13 (dca_port_13),
    .wb_bus      (u_wb_bus),
    .i_sum       (sum),
    .i_prod      (prod),
    .o_done      (o_done),
    .o_result    (o_result),
    .o_wmask     (o_wmask)
  );

endmodule

//--- ngemm_unit_tb.sv
`timescale 1ns/10ps

module ngemm_unit_tb;

  import ngemm_cfg_pkg::*;
  import ngemm_inst_pkg::*;

  localparam int ROUNDS          = 4;
  localparam int GAP_CYCLES      = 2;
  localparam int NUM_TESTS       = ROUNDS * 7 + 5;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (MAT_DIM + 2 + GAP_CYCLES) + 100;

  logic             dca_port_15;
  logic             dca_port_13;
  logic             i_clear;
  logic             i_start;
  op_e              i_op;
  dim_mask_t        i_row_mask;
  dim_mask_t        i_col_mask;
  logic [DIM_W-1:0] i_k_dim;
  matrix_t          i_lhs;
  matrix_t          i_rhs;
  logic             o_busy;
  logic             o_done;
  matrix_t          o_result;
  elem_mask_t       o_wmask;

  logic [31:0]      lcg_state = 32'h64b5_86e2;

  ngemm_tb_clock u_clock
  (
    .o_clk   (dca_port_15),
    .o_rst_n (dca_port_13)
  );

  ngemm_unit u_dut
  (
    .dca_port_15 (dca_port_15),
    .dca_port_13 (dca_port_13),
    .i_clear     (i_clear),
    .i_start     (i_start),
    .i_op        (i_op),
    .i_row_mask  (i_row_mask),
    .i_col_mask  (i_col_mask),
    .i_k_dim     (i_k_dim),
    .i_lhs       (i_lhs),
    .i_rhs       (i_rhs),
    .o_busy      (o_busy),
    .o_done      (o_done),
    .o_result    (o_result),
    .o_wmask     (o_wmask)
  );

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "Stopped at the first failed check");
  endtask

  // ******************************
  // Random stimulus
  // ******************************

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [15:0] next_rand();
    lcg_state = lcg_step(lcg_state);
    return lcg_state[31:16];
  endfunction

  function automatic matrix_t random_matrix();
    matrix_t m;
    for (int r = 0; r < MAT_DIM; r++)
    begin
      for (int c = 0; c < MAT_DIM; c++)
      begin
        m[r][c] = next_rand();
      end
    end
    return m;
  endfunction

  // ******************************
  // Reference model
  // ******************************

  function automatic int effective_k(input logic [DIM_W-1:0] k);
    return (k == '0) ? 1 : int'(k);
  endfunction

  function automatic matrix_t expected_result(input op_e op, input logic [DIM_W-1:0] k,
                                              input matrix_t a, input matrix_t b);
    matrix_t res;
    elem_t   acc;
    for (int r = 0; r < MAT_DIM; r++)
    begin
      for (int c = 0; c < MAT_DIM; c++)
      begin
        case (op)
          OP_ADD:    res[r][c] = a[r][c] + b[r][c];
          OP_SUB:    res[r][c] = a[r][c] - b[r][c];
          OP_EWMULT: res[r][c] = a[r][c] * b[r][c];
          default:
          begin
            acc = '0;
            for (int j = 0; j < effective_k(k); j++)
            begin
              acc = acc + a[r][j] * b[j][c];
            end
            res[r][c] = acc;
          end
        endcase
      end
    end
    return res;
  endfunction

  // Bit i covers row i/MAT_DIM and column i%MAT_DIM
  function automatic elem_mask_t expected_mask(input dim_mask_t rows, input dim_mask_t cols);
    elem_mask_t m;
    for (int i = 0; i < NUM_ELEM; i++)
    begin
      m[i] = rows[i / MAT_DIM] && cols[i % MAT_DIM];
    end
    return m;
  endfunction

  // ******************************
  // Checks
  // ******************************

  done_single_cycle: assert property (@(posedge dca_port_15) disable iff (!dca_port_13)
    o_done |=> !o_done)
    else report_failure("o_done stayed high for more than one cycle");

  done_ends_busy: assert property (@(posedge dca_port_15) disable iff (!dca_port_13)
    o_done |-> !o_busy)
    else report_failure("o_busy was still high while o_done was high");

  mask_only_with_done: assert property (@(posedge dca_port_15) disable iff (!dca_port_13)
    !o_done |-> (o_wmask == '0))
    else report_failure($sformatf("error o_wmask expected 0x0 actual 0x%h", $sampled(o_wmask)));

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else report_failure($sformatf("error %s expected 0x%0h actual 0x%0h", name, exp, act));
  endtask

  task automatic check_result(input matrix_t exp);
    for (int r = 0; r < MAT_DIM; r++)
    begin
      for (int c = 0; c < MAT_DIM; c++)
      begin
        check_value($sformatf("o_result[%0d][%0d]", r, c), exp[r][c], o_result[r][c]);
      end
    end
  endtask

  task automatic idle_cycles(input int count);
    repeat (count)
    begin
      @(negedge dca_port_15);
      check_value("o_done", 32'h0, o_done);
      check_value("o_busy", 32'h0, o_busy);
    end
  endtask

  // Starts one operation on a falling edge and follows it to done
  task automatic run_op(input op_e op, input logic [DIM_W-1:0] k, input logic poke_busy);
    matrix_t    lhs;
    matrix_t    rhs;
    dim_mask_t  rmask;
    dim_mask_t  cmask;
    matrix_t    exp_res;
    elem_mask_t exp_mask;
    int         lat;
    int         n;
    logic       seen;
    lhs      = random_matrix();
    rhs      = random_matrix();
    rmask    = dim_mask_t'(next_rand() >> 12);
    cmask    = dim_mask_t'(next_rand() >> 12);
    exp_res  = expected_result(op, k, lhs, rhs);
    exp_mask = expected_mask(rmask, cmask);
    lat      = (op == OP_MATMUL) ? effective_k(k) + 2 : 2;
    i_op       = op;
    i_k_dim    = k;
    i_row_mask = rmask;
    i_col_mask = cmask;
    i_lhs      = lhs;
    i_rhs      = rhs;
    i_start    = 1'b1;
    n    = 0;
    seen = 1'b0;
    while (!seen)
    begin
      @(negedge dca_port_15);
      n++;
      if (o_done)
      begin
        assert (n == lat + 1)
          else report_failure($sformatf("o_done rose %0d edges after start instead of %0d",
                                        n - 1, lat));
        check_value("o_busy", 32'h0, o_busy);
        check_result(exp_res);
        check_value("o_wmask", exp_mask, o_wmask);
        seen = 1'b1;
      end
      else
      begin
        assert (n < lat + 1)
          else report_failure($sformatf("o_done did not rise %0d edges after start", lat));
        check_value("o_busy", 32'h1, o_busy);
      end
      // A start while busy must be dropped
      i_start = poke_busy && (n == 2);
      if (n == 1)
      begin
        i_op       = OP_ADD;
        i_k_dim    = '0;
        i_row_mask = ~rmask;
        i_lhs      = ~lhs;
        i_rhs      = random_matrix();
      end
    end
  endtask

  task automatic clear_during_matmul();
    i_op       = OP_MATMUL;
    i_k_dim    = DIM_W'(MAT_DIM);
    i_row_mask = '1;
    i_col_mask = '1;
    i_lhs      = random_matrix();
    i_rhs      = random_matrix();
    i_start    = 1'b1;
    repeat (2)
    begin
      @(negedge dca_port_15);
      check_value("o_busy", 32'h1, o_busy);
      check_value("o_done", 32'h0, o_done);
      i_start = 1'b0;
    end
    i_clear = 1'b1;
    @(negedge dca_port_15);
    check_value("o_busy", 32'h0, o_busy);
    check_value("o_done", 32'h0, o_done);
    i_clear = 1'b0;
    idle_cycles(MAT_DIM + 4);
  endtask

  // ******************************
  // Main sequence and watchdog
  // ******************************

  initial
  begin
    i_clear    = 1'b0;
    i_start    = 1'b0;
    i_op       = OP_ADD;
    i_row_mask = '0;
    i_col_mask = '0;
    i_k_dim    = '0;
    i_lhs      = '0;
    i_rhs      = '0;
    wait (dca_port_13 === 1'b1);
    @(negedge dca_port_15);
    check_value("o_busy", 32'h0, o_busy);
    check_value("o_done", 32'h0, o_done);
    check_value("o_wmask", 32'h0, o_wmask);

    for (int round = 0; round < ROUNDS; round++)
    begin
      run_op(OP_ADD, '0, 1'b0);
      idle_cycles(GAP_CYCLES);
      run_op(OP_SUB, '0, 1'b0);
      idle_cycles(GAP_CYCLES);
      run_op(OP_EWMULT, '0, 1'b0);
      idle_cycles(GAP_CYCLES);
      for (int k = 1; k <= MAT_DIM; k++)
      begin
        run_op(OP_MATMUL, DIM_W'(k), 1'b0);
        idle_cycles(GAP_CYCLES);
      end
    end

    // Zero inner dimension runs as one step
    run_op(OP_MATMUL, '0, 1'b0);
    idle_cycles(GAP_CYCLES);

    run_op(OP_EWMULT, '0, 1'b1);
    idle_cycles(GAP_CYCLES);
    run_op(OP_MATMUL, DIM_W'(3), 1'b1);
    idle_cycles(GAP_CYCLES);

    clear_during_matmul();
    run_op(OP_MATMUL, DIM_W'(2), 1'b0);
    idle_cycles(GAP_CYCLES);

    $display("Regression passed");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge dca_port_15);
    report_failure($sformatf("Timeout: the run did not finish within %0d cycles",
                             WATCHDOG_CYCLES));
  end

endmodule

//--- result_writer.sv
`timescale 1ns/10ps

module result_writer
(
  input  logic                      dca_port_15,
  input  logic                      dca_port_13,
  wb_bus_if.writer                  wb_bus,
  input  ngemm_cfg_pkg::matrix_t    i_sum,
  input  ngemm_cfg_pkg::matrix_t    i_prod,
  output logic                      o_done,
  output ngemm_cfg_pkg::matrix_t    o_result,
  output ngemm_cfg_pkg::elem_mask_t o_wmask
);

  import ngemm_cfg_pkg::*;
  import ngemm_inst_pkg::*;

  elem_mask_t mask;

  // Outer product of row and column enables
  always_comb
  begin
    for (int r = 0; r < MAT_DIM; r++)
    begin
      for (int c = 0; c < MAT_DIM; c++)
      begin
        mask[r*MAT_DIM + c] = wb_bus.row_mask[r] & wb_bus.col_mask[c];
      end
    end
  end

  // ******************************
  // Done strobe and write mask
  // ******************************

  always_ff @(posedge dca_port_15, negedge dca_port_13)
  begin
    if (!dca_port_13)
    begin
      o_done  <= 1'b0;
      o_wmask <= '0;
    end
    else
    begin
      o_done  <= wb_bus.valid;
      o_wmask <= wb_bus.valid ? mask : '0;
    end
  end

  // Result holds until the next write-back
  always_ff @(posedge dca_port_15)
  begin
    if (wb_bus.valid)
      o_result <= (wb_bus.src == SRC_MUL) ? i_prod : i_sum;
  end

endmodule

//--- wb_bus_if.sv
`timescale 1ns/10ps

interface wb_bus_if;

  import ngemm_cfg_pkg::*;
  import ngemm_inst_pkg::*;

  // High while the chosen array output is final
  logic      valid;
  src_e      src;
  dim_mask_t row_mask;
  dim_mask_t col_mask;

  modport seq
  (
    output valid,
    output src,
    output row_mask,
    output col_mask
  );

  modport writer
  (
    input  valid,
    input  src,
    input  row_mask,
    input  col_mask
  );

endinterface
